/* rtl/roce_setup_pkg.sv */
// shared types and constants for the roce_setup engine
// packed entries put the first stack field at bit 0, so fields are listed msb first
// timing constants are in net_clk cycles
package roce_setup_pkg;

  ////////////////////////////////
  // field widths
  ////////////////////////////////
  localparam int QPN_W   = 24;
  localparam int PSN_W   = 24;
  localparam int RKEY_W  = 16;
  localparam int VADDR_W = 48;
  localparam int IP_W    = 32;
  localparam int PORT_W  = 16;
  localparam int GAP_W   = 9;   // wide enough for the long gap

  ////////////////////////////////
  // encodings and timing
  ////////////////////////////////
  localparam logic [2:0]         QP_STATE_READY_RECV = 3'd2;
  localparam logic [2:0]         OP_RDMA_READ        = 3'd0;
  localparam logic [2:0]         OP_RDMA_WRITE       = 3'd1;
  localparam logic [47:0]        META_WRITE_LADDR    = 48'd4;  // local addr of the write
  localparam logic [GAP_W-1:0]   META_GAP_LONG       = 9'd500; // after read and write
  localparam logic [GAP_W-1:0]   META_GAP_SHORT      = 9'd100; // after the last read
  localparam logic [31:0]        RUN_CYCLES          = 32'd3000;
  localparam logic [IP_W-1:0]    LOCAL_IP_RESET      = 32'hD1D4010B;

  // queue pair entry, 144 bits
  typedef struct packed {
    logic [4:0]         pad;
    logic [VADDR_W-1:0] v_addr;
    logic [RKEY_W-1:0]  r_key;
    logic [PSN_W-1:0]   local_psn;
    logic [PSN_W-1:0]   remote_psn;
    logic [QPN_W-1:0]   qpn;
    logic [2:0]         qp_state;   // bits 2:0
  } qp_entry_t;

  // connection entry, 184 bits
  typedef struct packed {
    logic [PORT_W-1:0]  remote_udp_port;
    logic [IP_W-1:0]    remote_ip;
    logic [95:0]        reserved;
    logic [QPN_W-1:0]   remote_qpn;
    logic [15:0]        local_qpn;  // bits 15:0
  } conn_entry_t;

  // tx metadata command, 160 bits
  typedef struct packed {
    logic [4:0]         pad;
    logic [31:0]        length;
    logic [47:0]        remote_addr;
    logic [47:0]        local_addr;
    logic [QPN_W-1:0]   qpn;
    logic [2:0]         op_code;    // bits 2:0
  } tx_meta_t;

endpackage

/* rtl/ap_ctrl.sv */
// kernel style start/idle/done/ready control
// ap_start is a level, done and ready are the same one cycle pulse
// run timer only advances while ap_start stays high
`timescale 1ns/1ps

module ap_ctrl (
  input  logic net_clk,
  input  logic net_aresetn,
  input  logic ap_start,
  output logic start_pulse,
  output logic ap_idle,
  output logic ap_done,
  output logic ap_ready
);

  logic        start_r;   // ap_start one cycle back
  logic [31:0] run_cnt;

  assign start_pulse = ap_start & ~start_r;  // rising edge of start

  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      start_r <= 1'b0;
      ap_idle <= 1'b1;
    end else begin
      start_r <= ap_start;
      if (ap_done) begin
        ap_idle <= 1'b1;            // back to idle after done
      end else if (start_pulse) begin
        ap_idle <= 1'b0;
      end
    end
  end

  ////////////////////////////////
  // run timer
  ////////////////////////////////
  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      run_cnt <= '0;
      ap_done <= 1'b0;
    end else begin
      ap_done <= 1'b0;               // single cycle pulse
      if (run_cnt == roce_setup_pkg::RUN_CYCLES) begin
        run_cnt <= '0;
        ap_done <= 1'b1;
      end else if (ap_start) begin
        run_cnt <= run_cnt + 32'd1;
      end
    end
  end

  assign ap_ready = ap_done;  // non pipelined kernel

endmodule

/* rtl/session_params.sv */
// snapshot of the host session parameters, taken on start_pulse
// host fields are wider than the stack needs, upper bits are dropped
// local ip is stored byte reversed for the stack
`timescale 1ns/1ps

module session_params (
  input  logic                                 net_clk,
  input  logic                                 net_aresetn,
  input  logic                                 start_pulse,
  input  logic [31:0]                          r_psn,
  input  logic [31:0]                          l_psn,
  input  logic [31:0]                          r_qpn,
  input  logic [31:0]                          l_qpn,
  input  logic [31:0]                          r_ip,
  input  logic [31:0]                          l_ip,
  input  logic [31:0]                          r_udp,
  input  logic [31:0]                          r_key,
  input  logic [31:0]                          len,
  input  logic [63:0]                          v_addr,
  output logic [roce_setup_pkg::PSN_W-1:0]     s_r_psn,
  output logic [roce_setup_pkg::PSN_W-1:0]     s_l_psn,
  output logic [roce_setup_pkg::QPN_W-1:0]     s_r_qpn,
  output logic [roce_setup_pkg::QPN_W-1:0]     s_l_qpn,
  output logic [roce_setup_pkg::IP_W-1:0]      s_r_ip,
  output logic [roce_setup_pkg::PORT_W-1:0]    s_r_udp,
  output logic [roce_setup_pkg::RKEY_W-1:0]    s_r_key,
  output logic [roce_setup_pkg::VADDR_W-1:0]   s_v_addr,
  output logic [31:0]                          s_len,
  output logic [roce_setup_pkg::IP_W-1:0]      local_ip
);

  // session fields, stable for the whole sequence
  always_ff @(posedge net_clk) begin
    if (start_pulse) begin
      s_r_psn  <= r_psn[roce_setup_pkg::PSN_W-1:0];
      s_l_psn  <= l_psn[roce_setup_pkg::PSN_W-1:0];
      s_r_qpn  <= r_qpn[roce_setup_pkg::QPN_W-1:0];
      s_l_qpn  <= l_qpn[roce_setup_pkg::QPN_W-1:0];
      s_r_ip   <= r_ip;
      s_r_udp  <= r_udp[roce_setup_pkg::PORT_W-1:0];
      s_r_key  <= r_key[roce_setup_pkg::RKEY_W-1:0];
      s_v_addr <= v_addr[roce_setup_pkg::VADDR_W-1:0];  // 48 bit virtual addr
      s_len    <= len;
    end
  end

  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      local_ip <= roce_setup_pkg::LOCAL_IP_RESET;
    end else if (start_pulse) begin
      local_ip <= {<<8{l_ip}};       // byte swap
    end
  end

endmodule

/* rtl/qp_setup_fsm.sv */
// issues the fixed setup sequence: 2 qp entries, 2 conn entries, 3 tx meta
// runs once per reset, later starts are ignored
// every command holds until accepted, meta steps also wait out a gap
`timescale 1ns/1ps

module qp_setup_fsm (
  input  logic                                 net_clk,
  input  logic                                 net_aresetn,
  input  logic                                 start_pulse,
  input  logic [roce_setup_pkg::PSN_W-1:0]     s_r_psn,
  input  logic [roce_setup_pkg::PSN_W-1:0]     s_l_psn,
  input  logic [roce_setup_pkg::QPN_W-1:0]     s_r_qpn,
  input  logic [roce_setup_pkg::QPN_W-1:0]     s_l_qpn,
  input  logic [roce_setup_pkg::IP_W-1:0]      s_r_ip,
  input  logic [roce_setup_pkg::PORT_W-1:0]    s_r_udp,
  input  logic [roce_setup_pkg::RKEY_W-1:0]    s_r_key,
  input  logic [roce_setup_pkg::VADDR_W-1:0]   s_v_addr,
  input  logic [31:0]                          s_len,
  output logic                                 qp_valid,
  input  logic                                 qp_ready,
  output roce_setup_pkg::qp_entry_t            qp_data,
  output logic                                 conn_valid,
  input  logic                                 conn_ready,
  output roce_setup_pkg::conn_entry_t          conn_data,
  output logic                                 meta_valid,
  input  logic                                 meta_ready,
  output roce_setup_pkg::tx_meta_t             meta_data
);

  typedef enum logic [2:0] {
    IDLE, QP_REMOTE, QP_LOCAL, CONN_FWD, CONN_REV, META_READ, META_WRITE, META_READ_2
  } state_t;

  state_t                             state;
  logic                               seq_done;   // sequence already ran
  logic                               meta_sent;  // current meta cmd accepted
  logic [roce_setup_pkg::GAP_W-1:0]   gap_cnt;
  logic [roce_setup_pkg::GAP_W-1:0]   gap_lim;
  logic                               meta_state;
  logic                               gap_ok;
  logic                               qp_fire;
  logic                               conn_fire;
  logic                               meta_fire;

  assign meta_state = (state == META_READ) || (state == META_WRITE) || (state == META_READ_2);
  assign qp_valid   = (state == QP_REMOTE) || (state == QP_LOCAL);
  assign conn_valid = (state == CONN_FWD) || (state == CONN_REV);
  assign meta_valid = meta_state && !meta_sent;  // one shot per meta state
  assign qp_fire    = qp_valid && qp_ready;
  assign conn_fire  = conn_valid && conn_ready;
  assign meta_fire  = meta_valid && meta_ready;

  // last read only needs the short gap
  assign gap_lim = (state == META_READ_2) ? roce_setup_pkg::META_GAP_SHORT :
                                            roce_setup_pkg::META_GAP_LONG;
  assign gap_ok  = meta_sent && (gap_cnt == gap_lim);

  ////////////////////////////////
  // sequencer
  ////////////////////////////////
  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      state     <= IDLE;
      seq_done  <= 1'b0;
      meta_sent <= 1'b0;
      gap_cnt   <= '0;
    end else begin
      case (state)
        IDLE:        if (start_pulse && !seq_done) state <= QP_REMOTE;
        QP_REMOTE:   if (qp_fire) state <= QP_LOCAL;
        QP_LOCAL:    if (qp_fire) state <= CONN_FWD;
        CONN_FWD:    if (conn_fire) state <= CONN_REV;
        CONN_REV:    if (conn_fire) state <= META_READ;
        META_READ:   if (gap_ok) state <= META_WRITE;
        META_WRITE:  if (gap_ok) state <= META_READ_2;
        META_READ_2: begin
          if (gap_ok) begin
            state    <= IDLE;
            seq_done <= 1'b1;          // stay idle until reset
          end
        end
        default:     state <= IDLE;
      endcase

      // gap counts from acceptance, not from state entry
      if (meta_fire) begin
        meta_sent <= 1'b1;
        gap_cnt   <= '0;
      end else if (gap_ok) begin
        meta_sent <= 1'b0;
        gap_cnt   <= '0;
      end else if (meta_sent) begin
        gap_cnt   <= gap_cnt + 1'b1;
      end
    end
  end

  ////////////////////////////////
  // command payloads
  ////////////////////////////////
  always_comb begin
    qp_data          = '0;            // pad stays zero
    qp_data.qp_state = roce_setup_pkg::QP_STATE_READY_RECV;
    qp_data.r_key    = s_r_key;
    qp_data.v_addr   = s_v_addr;
    if (state == QP_LOCAL) begin
      qp_data.qpn        = s_l_qpn;
      qp_data.remote_psn = s_l_psn;   // psns swapped for the local side
      qp_data.local_psn  = s_r_psn;
    end else begin
      qp_data.qpn        = s_r_qpn;
      qp_data.remote_psn = s_r_psn;
      qp_data.local_psn  = s_l_psn;
    end

    conn_data                 = '0;   // reserved stays zero
    conn_data.remote_udp_port = s_r_udp;
    if (state == CONN_REV) begin
      conn_data.local_qpn  = s_r_qpn[15:0];
      conn_data.remote_qpn = s_l_qpn;
      conn_data.remote_ip  = s_r_ip;
    end else begin
      conn_data.local_qpn  = s_l_qpn[15:0];
      conn_data.remote_qpn = s_r_qpn;
      conn_data.remote_ip  = {<<8{s_r_ip}};  // byte reversed
    end

    meta_data        = '0;            // remote addr and pad zero
    meta_data.qpn    = s_l_qpn;
    meta_data.length = s_len;
    if (state == META_WRITE) begin
      meta_data.op_code    = roce_setup_pkg::OP_RDMA_WRITE;
      meta_data.local_addr = roce_setup_pkg::META_WRITE_LADDR;
    end else begin
      meta_data.op_code    = roce_setup_pkg::OP_RDMA_READ;
    end
  end

endmodule

/* rtl/cmd_slice.sv */
// two entry valid/ready register slice, full throughput
// in_ready is registered and only depends on the skid entry
`timescale 1ns/1ps

module cmd_slice #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     net_clk,
  input  logic     net_aresetn,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  logic     skid_valid;
  payload_t skid_data;
  logic     load_main;   // output register free or draining this cycle
  logic     load_skid;   // output stalled, park the input

  assign in_ready  = ~skid_valid;  // full only when skid holds an entry
  assign load_main = out_ready | ~out_valid;
  assign load_skid = in_valid & in_ready & ~load_main;

  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
    end else if (load_main) begin
      out_valid  <= skid_valid | in_valid;  // skid drains first
      skid_valid <= 1'b0;
    end else if (load_skid) begin
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge net_clk) begin
    if (load_main) begin
      out_data <= skid_valid ? skid_data : in_data;
    end
    if (load_skid) begin
      skid_data <= in_data;
    end
  end

endmodule

/* rtl/roce_setup_top.sv */
// roce connection setup engine, host side
// one session per reset, commands leave through registered slices
`timescale 1ns/1ps

module roce_setup_top (
  input  logic                                net_clk,
  input  logic                                net_aresetn,
  input  logic                                ap_start,
  output logic                                ap_idle,
  output logic                                ap_done,
  output logic                                ap_ready,
  input  logic [31:0]                         r_psn,
  input  logic [31:0]                         l_psn,
  input  logic [31:0]                         r_qpn,
  input  logic [31:0]                         l_qpn,
  input  logic [31:0]                         r_ip,
  input  logic [31:0]                         l_ip,
  input  logic [31:0]                         r_udp,
  input  logic [31:0]                         r_key,
  input  logic [31:0]                         len,
  input  logic [63:0]                         v_addr,
  output logic                                qp_valid,
  input  logic                                qp_ready,
  output roce_setup_pkg::qp_entry_t           qp_data,
  output logic                                conn_valid,
  input  logic                                conn_ready,
  output roce_setup_pkg::conn_entry_t         conn_data,
  output logic                                meta_valid,
  input  logic                                meta_ready,
  output roce_setup_pkg::tx_meta_t            meta_data,
  output logic [roce_setup_pkg::IP_W-1:0]     local_ip
);

  logic                                start_pulse;
  logic [roce_setup_pkg::PSN_W-1:0]    s_r_psn;
  logic [roce_setup_pkg::PSN_W-1:0]    s_l_psn;
  logic [roce_setup_pkg::QPN_W-1:0]    s_r_qpn;
  logic [roce_setup_pkg::QPN_W-1:0]    s_l_qpn;
  logic [roce_setup_pkg::IP_W-1:0]     s_r_ip;
  logic [roce_setup_pkg::PORT_W-1:0]   s_r_udp;
  logic [roce_setup_pkg::RKEY_W-1:0]   s_r_key;
  logic [roce_setup_pkg::VADDR_W-1:0]  s_v_addr;
  logic [31:0]                         s_len;

  // sequencer side of the slices
  logic                                fsm_qp_valid;
  logic                                fsm_qp_ready;
  roce_setup_pkg::qp_entry_t           fsm_qp_data;
  logic                                fsm_conn_valid;
  logic                                fsm_conn_ready;
  roce_setup_pkg::conn_entry_t         fsm_conn_data;
  logic                                fsm_meta_valid;
  logic                                fsm_meta_ready;
  roce_setup_pkg::tx_meta_t            fsm_meta_data;

  ap_ctrl u_ap_ctrl (
    .net_clk, .net_aresetn, .ap_start, .start_pulse, .ap_idle, .ap_done, .ap_ready
  );

  session_params u_session_params (
    .net_clk, .net_aresetn, .start_pulse,
    .r_psn, .l_psn, .r_qpn, .l_qpn, .r_ip, .l_ip, .r_udp, .r_key, .len, .v_addr,
    .s_r_psn, .s_l_psn, .s_r_qpn, .s_l_qpn, .s_r_ip, .s_r_udp, .s_r_key, .s_v_addr,
    .s_len, .local_ip
  );

  qp_setup_fsm u_qp_setup_fsm (
    .net_clk, .net_aresetn, .start_pulse,
    .s_r_psn, .s_l_psn, .s_r_qpn, .s_l_qpn, .s_r_ip, .s_r_udp, .s_r_key, .s_v_addr,
    .s_len,
    .qp_valid   (fsm_qp_valid),   .qp_ready   (fsm_qp_ready),   .qp_data   (fsm_qp_data),
    .conn_valid (fsm_conn_valid), .conn_ready (fsm_conn_ready), .conn_data (fsm_conn_data),
    .meta_valid (fsm_meta_valid), .meta_ready (fsm_meta_ready), .meta_data (fsm_meta_data)
  );

  cmd_slice #(.payload_t(roce_setup_pkg::qp_entry_t)) qp_slice (
    .net_clk, .net_aresetn,
    .in_valid  (fsm_qp_valid), .in_ready  (fsm_qp_ready), .in_data  (fsm_qp_data),
    .out_valid (qp_valid),     .out_ready (qp_ready),     .out_data (qp_data)
  );

  cmd_slice #(.payload_t(roce_setup_pkg::conn_entry_t)) conn_slice (
    .net_clk, .net_aresetn,
    .in_valid  (fsm_conn_valid), .in_ready  (fsm_conn_ready), .in_data  (fsm_conn_data),
    .out_valid (conn_valid),     .out_ready (conn_ready),     .out_data (conn_data)
  );

  cmd_slice #(.payload_t(roce_setup_pkg::tx_meta_t)) meta_slice (
    .net_clk, .net_aresetn,
    .in_valid  (fsm_meta_valid), .in_ready  (fsm_meta_ready), .in_data  (fsm_meta_data),
    .out_valid (meta_valid),     .out_ready (meta_ready),     .out_data (meta_data)
  );

endmodule

/* bench/roce_setup_tb.sv */
// one setup session per table row, with a reset before each row
// ready inputs are random from a fixed seed lfsr, clock period 40 ns
// each row runs about RUN_CYCLES cycles, the watchdog allows for that
`timescale 1ns/1ps

module roce_setup_tb;

  localparam int     CLK_PERIOD  = 40;
  localparam int     NUM_ROWS    = 3;
  localparam int     RUN         = roce_setup_pkg::RUN_CYCLES;
  localparam int     GAP_LONG    = roce_setup_pkg::META_GAP_LONG;
  localparam longint WATCHDOG_NS = longint'(NUM_ROWS) * (RUN + 200) * CLK_PERIOD;

  typedef struct packed {
    logic [31:0] r_psn, l_psn, r_qpn, l_qpn;
    logic [31:0] r_ip, l_ip, r_udp, r_key, len;
    logic [63:0] v_addr;
    logic [31:0] exp_local_ip;   // l_ip byte reversed
  } session_row_t;

  logic                        net_clk;
  logic                        net_aresetn;
  logic                        ap_start, ap_idle, ap_done, ap_ready;
  logic [31:0]                 r_psn, l_psn, r_qpn, l_qpn, r_ip, l_ip, r_udp, r_key, len;
  logic [63:0]                 v_addr;
  logic                        qp_valid, qp_ready, conn_valid, conn_ready;
  logic                        meta_valid, meta_ready;
  roce_setup_pkg::qp_entry_t   qp_data;
  roce_setup_pkg::conn_entry_t conn_data;
  roce_setup_pkg::tx_meta_t    meta_data;
  logic [31:0]                 local_ip;

  session_row_t                rows [NUM_ROWS];
  logic [31:0]                 lfsr_state;
  int                          cyc;             // negedge count
  int                          cur_row;
  int                          offer_cyc;       // meta cmd first seen at output
  int                          prev_offer_cyc;
  logic                        meta_offered;
  roce_setup_pkg::qp_entry_t   qp_q [$];        // accepted commands
  roce_setup_pkg::conn_entry_t conn_q [$];
  roce_setup_pkg::tx_meta_t    meta_q [$];

  roce_setup_top DUT (.*);

  initial begin
    net_clk = 1'b0;
    forever #(CLK_PERIOD / 2) net_clk = ~net_clk;
  end

  // hang guard
  initial begin
    #(WATCHDOG_NS);
    $display("run timed out before all sessions finished");
    $display("Test failed");
    $fatal(1, "watchdog expired");
  end

  //////////////////////////////
  // helpers
  //////////////////////////////
  task automatic check_value(input string name, input logic [191:0] expected,
                             input logic [191:0] actual);
    if (expected !== actual) begin
      $display("FAILED %s expected %0h actual %0h", name, expected, actual);
      $display("Test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // galois lfsr, one step per bit
  function automatic logic next_random_bit();
    logic b;
    b          = lfsr_state[0];
    lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
    return b;
  endfunction

  function automatic logic [31:0] swap_bytes(input logic [31:0] x);
    return {x[7:0], x[15:8], x[23:16], x[31:24]};
  endfunction

  function automatic roce_setup_pkg::qp_entry_t expect_qp(input session_row_t r, input bit lcl);
    roce_setup_pkg::qp_entry_t e;
    e          = '0;
    e.qp_state = roce_setup_pkg::QP_STATE_READY_RECV;
    e.r_key    = r.r_key[15:0];
    e.v_addr   = r.v_addr[47:0];
    e.qpn        = lcl ? r.l_qpn[23:0] : r.r_qpn[23:0];
    e.remote_psn = lcl ? r.l_psn[23:0] : r.r_psn[23:0];   // psns swap on the local entry
    e.local_psn  = lcl ? r.r_psn[23:0] : r.l_psn[23:0];
    return e;
  endfunction

  function automatic roce_setup_pkg::conn_entry_t expect_conn(input session_row_t r,
                                                              input bit rev);
    roce_setup_pkg::conn_entry_t e;
    e                 = '0;
    e.remote_udp_port = r.r_udp[15:0];
    e.local_qpn       = rev ? r.r_qpn[15:0] : r.l_qpn[15:0];
    e.remote_qpn      = rev ? r.l_qpn[23:0] : r.r_qpn[23:0];
    e.remote_ip       = rev ? r.r_ip : swap_bytes(r.r_ip);
    return e;
  endfunction

  function automatic roce_setup_pkg::tx_meta_t expect_meta(input session_row_t r, input int k);
    roce_setup_pkg::tx_meta_t e;
    e            = '0;
    e.qpn        = r.l_qpn[23:0];
    e.length     = r.len;
    e.op_code    = (k == 1) ? roce_setup_pkg::OP_RDMA_WRITE : roce_setup_pkg::OP_RDMA_READ;
    e.local_addr = (k == 1) ? roce_setup_pkg::META_WRITE_LADDR : 48'd0;
    return e;
  endfunction

  task automatic drive_session(input session_row_t r);
    r_psn  = r.r_psn;
    l_psn  = r.l_psn;
    r_qpn  = r.r_qpn;
    l_qpn  = r.l_qpn;
    r_ip   = r.r_ip;
    l_ip   = r.l_ip;
    r_udp  = r.r_udp;
    r_key  = r.r_key;
    len    = r.len;
    v_addr = r.v_addr;
  endtask

  // one cycle: new ready bits on the falling edge, then log what the next rise accepts
  task automatic step_cycle();
    @(negedge net_clk);
    cyc++;
    qp_ready   = next_random_bit();
    conn_ready = next_random_bit();
    meta_ready = next_random_bit();
    if (qp_valid && qp_ready) qp_q.push_back(qp_data);
    if (conn_valid && conn_ready) conn_q.push_back(conn_data);
    if (meta_valid && !meta_offered) begin
      meta_offered = 1'b1;
      offer_cyc    = cyc;
    end
    if (meta_valid && meta_ready) begin
      if (meta_q.size() > 0)
        check_value($sformatf("row %0d meta gap", cur_row), 1'b1,
                    (cyc - prev_offer_cyc) >= GAP_LONG);
      prev_offer_cyc = offer_cyc;
      meta_offered   = 1'b0;
      meta_q.push_back(meta_data);
    end
  endtask

  //////////////////////////////
  // one session
  //////////////////////////////
  task automatic run_row(input int idx);
    session_row_t r;
    int           start_cyc;
    r       = rows[idx];
    cur_row = idx;
    step_cycle();
    net_aresetn = 1'b0;
    ap_start    = 1'b0;
    drive_session(r);
    repeat (3) step_cycle();
    // idle, done, ready, qp, conn, meta valid
    check_value($sformatf("row %0d reset flags", idx), 6'b100000,
                {ap_idle, ap_done, ap_ready, qp_valid, conn_valid, meta_valid});
    check_value($sformatf("row %0d reset local_ip", idx), roce_setup_pkg::LOCAL_IP_RESET,
                local_ip);
    net_aresetn = 1'b1;
    qp_q.delete();
    conn_q.delete();
    meta_q.delete();
    meta_offered = 1'b0;
    step_cycle();
    ap_start  = 1'b1;                  // held high for the whole run
    start_cyc = cyc;
    step_cycle();
    check_value($sformatf("row %0d idle after start", idx), 1'b0, ap_idle);
    check_value($sformatf("row %0d local_ip", idx), r.exp_local_ip, local_ip);
    while (!ap_done) begin
      check_value($sformatf("row %0d ap_ready", idx), 1'b0, ap_ready);
      step_cycle();
    end
    check_value($sformatf("row %0d done latency", idx), RUN + 1, cyc - start_cyc);
    check_value($sformatf("row %0d ready with done", idx), 1'b1, ap_ready);
    check_value($sformatf("row %0d qp count", idx), 2, qp_q.size());
    check_value($sformatf("row %0d conn count", idx), 2, conn_q.size());
    check_value($sformatf("row %0d meta count", idx), 3, meta_q.size());
    step_cycle();
    check_value($sformatf("row %0d done width", idx), 2'b00, {ap_done, ap_ready});
    check_value($sformatf("row %0d idle after done", idx), 1'b1, ap_idle);
    for (int i = 0; i < 2; i++) begin
      check_value($sformatf("row %0d qp %0d", idx, i), expect_qp(r, i == 1), qp_q[i]);
      check_value($sformatf("row %0d conn %0d", idx, i), expect_conn(r, i == 1), conn_q[i]);
    end
    for (int i = 0; i < 3; i++)
      check_value($sformatf("row %0d meta %0d", idx, i), expect_meta(r, i), meta_q[i]);
  endtask

  initial begin
    // r_psn l_psn r_qpn l_qpn / r_ip l_ip r_udp r_key len / v_addr exp_local_ip
    rows[0] = '{32'hAB123456, 32'h00654321, 32'h00000011, 32'h00000012,
                32'h0B01D4D1, 32'h0A01D4D1, 32'h000012B7, 32'h00001234, 32'h00000040,
                64'h0000_1000_2000_3000, 32'hD1D4010A};
    rows[1] = '{32'h00FFFFFF, 32'h00000000, 32'h12ABCDEF, 32'h00345678,
                32'hC0A80105, 32'hC0A80107, 32'hFFFF4791, 32'h5A5ABEEF, 32'h00010000,
                64'hFFFF_8000_0000_0001, 32'h0701A8C0};  // upper bits dropped by the dut
    rows[2] = '{32'h00000001, 32'h00000002, 32'h00000100, 32'h00000200,
                32'h01020304, 32'h11223344, 32'h00001000, 32'h00000001, 32'hFFFFFFFF,
                64'h0000_0000_DEAD_BEEF, 32'h44332211};
    lfsr_state  = 32'had1a;
    cyc         = 0;
    net_aresetn = 1'b0;
    ap_start    = 1'b0;
    qp_ready    = 1'b0;
    conn_ready  = 1'b0;
    meta_ready  = 1'b0;
    drive_session(rows[0]);
    for (int i = 0; i < NUM_ROWS; i++) run_row(i);
    $display("Test completed successfully");
    $finish;
  end

endmodule

/* roce_setup.f */
rtl/roce_setup_pkg.sv
rtl/ap_ctrl.sv
rtl/session_params.sv
rtl/qp_setup_fsm.sv
rtl/cmd_slice.sv
rtl/roce_setup_top.sv
bench/roce_setup_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the roce_setup testbench with verilator, verdict taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module roce_setup_tb -f roce_setup.f \
  > build.log 2>&1 && ./obj_dir/Vroce_setup_tb > sim.log 2>&1 || echo "build or run error"
[ -f sim.log ] && cat sim.log
grep -q "Test failed" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "Test completed successfully" sim.log || { echo "no pass result in sim.log"; exit 1; }
echo "simulation passed"
